// ==== hdl/flappy_pkg.sv ====
package flappy_pkg;

   // visible raster
   localparam int h_valid    = 640;
   localparam int v_valid    = 480;
   localparam int coord_w    = 10;
   localparam int ground_top = 352;  // first grass row
   localparam int death_y    = 420;  // bird below this row is dead

   // bird box and motion
   localparam int bird_w     = 32;
   localparam int bird_h     = 32;
   localparam int bird_x0    = 303;
   localparam int bird_y0    = 223;
   localparam int fall_step  = 2;    // rows per frame while falling
   localparam int steer_step = 5;

   // rise profile after a flap, one entry per frame
   localparam int rise_step [8] = '{20, 16, 12, 8, 6, 4, 2, 1};

   // pipes
   localparam int pipe_w      = 32;
   localparam int seg_h       = 32;
   localparam int head_h      = 16;
   localparam int gap_segs    = 6;   // opening height in segments
   localparam int pipe_step   = 2;
   localparam int pipe_wrap_x = 608;
   localparam int pipe1_x0    = 576;
   localparam int pipe2_x0    = 305;

   localparam int len_w       = 3;
   localparam int pipe1_len0  = 3;
   localparam int pipe2_len0  = 5;
   localparam int len_min     = 2;
   localparam int len_max     = 6;

   // score counter wraps
   localparam int score_w = 7;

   // game over banner
   localparam int over_x0 = 191;
   localparam int over_x1 = 446;
   localparam int over_y0 = 207;
   localparam int over_y1 = 270;

   // RGB565 palette
   localparam logic [15:0] col_sky       = 16'h4E19;
   localparam logic [15:0] col_ground    = 16'h8B20;
   localparam logic [15:0] col_pipe_body = 16'h07E0;
   localparam logic [15:0] col_pipe_head = 16'h03E0;
   localparam logic [15:0] col_bird_down = 16'hFFE0;
   localparam logic [15:0] col_bird_up   = 16'hFD20;  // wing raised
   localparam logic [15:0] col_over      = 16'hF800;

endpackage

// ==== hdl/flight_ctrl.sv ====
`timescale 1ns/10ps

module flight_ctrl (
   input  logic                           vga_clk,
   input  logic                           sys_rst_n,
   input  logic [flappy_pkg::coord_w-1:0] pix_x,
   input  logic [flappy_pkg::coord_w-1:0] pix_y,
   input  logic                           flap_n,
   input  logic                           left_n,
   input  logic                           right_n,
   input  logic                           run,
   input  logic                           bird_on,
   input  logic                           pipe_body_on,
   input  logic                           pipe_head_on,
   output logic [flappy_pkg::coord_w-1:0] bird_x,
   output logic [flappy_pkg::coord_w-1:0] bird_y,
   output logic [flappy_pkg::coord_w-1:0] pipe1_x,
   output logic [flappy_pkg::coord_w-1:0] pipe2_x,
   output logic [flappy_pkg::len_w-1:0]   pipe1_len,
   output logic [flappy_pkg::len_w-1:0]   pipe2_len,
   output logic                           wing_up,
   output logic                           game_over,
   output logic [flappy_pkg::score_w-1:0] score
);
   import flappy_pkg::*;

   logic               frame_tick;    // first pixel of the frame
   logic               advance;       // tick on which the world moves
   logic [3:0]         phase;         // 0..7 falling and 8..15 rising
   logic [3:0]         wing_cnt;
   logic               hit_pipe;
   logic               out_of_bounds;
   logic               pass_pipe;

   // pipe scrolls left and reappears at the right edge
   function automatic logic [coord_w-1:0] scroll_x(input logic [coord_w-1:0] x);
      if (x > coord_w'(pipe_step))
         return x - coord_w'(pipe_step);
      return coord_w'(pipe_wrap_x);
   endfunction

   // a new length is picked only when the pipe wraps
   function automatic logic [len_w-1:0] next_len(
      input logic [coord_w-1:0] x,
      input logic [len_w-1:0]   len
   );
      if (x > coord_w'(pipe_step))
         return len;
      if (len > len_w'(len_max))
         return len_w'(len_min);
      return len + len_w'(1);
   endfunction

   assign frame_tick = (pix_x == '0) && (pix_y == '0);
   assign advance    = frame_tick && run && !game_over;

   // vertical motion
   always_ff @(posedge vga_clk or negedge sys_rst_n) begin
      if (!sys_rst_n) begin
         phase  <= '0;
         bird_y <= coord_w'(bird_y0);
      end else if (advance) begin
         if (!phase[3]) begin
            bird_y <= bird_y + coord_w'(fall_step);
            if (!flap_n)
               phase <= 4'd8;  // start of the rise
            else if (phase != 4'd7)
               phase <= phase + 4'd1;
         end else begin
            bird_y <= bird_y - coord_w'(rise_step[phase[2:0]]);
            phase  <= phase + 4'd1;  // 15 rolls back into the fall
         end
      end
   end

   // left key wins over the right key
   always_ff @(posedge vga_clk or negedge sys_rst_n) begin
      if (!sys_rst_n) begin
         bird_x <= coord_w'(bird_x0);
      end else if (advance) begin
         if (!left_n)
            bird_x <= bird_x - coord_w'(steer_step);
         else if (!right_n)
            bird_x <= bird_x + coord_w'(steer_step);
      end
   end

   always_ff @(posedge vga_clk or negedge sys_rst_n) begin
      if (!sys_rst_n) begin
         pipe1_x   <= coord_w'(pipe1_x0);
         pipe2_x   <= coord_w'(pipe2_x0);
         pipe1_len <= len_w'(pipe1_len0);
         pipe2_len <= len_w'(pipe2_len0);
      end else if (advance) begin
         pipe1_x   <= scroll_x(pipe1_x);
         pipe2_x   <= scroll_x(pipe2_x);
         pipe1_len <= next_len(pipe1_x, pipe1_len);
         pipe2_len <= next_len(pipe2_x, pipe2_len);
      end
   end

   // wing flaps on its own even while paused
   always_ff @(posedge vga_clk or negedge sys_rst_n) begin
      if (!sys_rst_n)
         wing_cnt <= '0;
      else if (frame_tick)
         wing_cnt <= wing_cnt + 4'd1;
   end

   assign wing_up = wing_cnt[3];

   // bird column lines up with a pipe edge on an even or odd step
   assign pass_pipe = (bird_x == pipe1_x) || (bird_x == pipe1_x - coord_w'(1)) ||
                      (bird_x == pipe2_x) || (bird_x == pipe2_x - coord_w'(1));

   always_ff @(posedge vga_clk or negedge sys_rst_n) begin
      if (!sys_rst_n)
         score <= '0;
      else if (frame_tick && pass_pipe && !game_over)
         score <= score + score_w'(1);
   end

   assign hit_pipe      = bird_on && (pipe_body_on || pipe_head_on);
   assign out_of_bounds = (bird_y > coord_w'(death_y)) || (bird_x > coord_w'(h_valid));

   // sticky until reset
   always_ff @(posedge vga_clk or negedge sys_rst_n) begin
      if (!sys_rst_n)
         game_over <= 1'b0;
      else if (hit_pipe || out_of_bounds)
         game_over <= 1'b1;
   end

endmodule

// ==== hdl/layer_hit.sv ====
`timescale 1ns/10ps

module layer_hit (
   input  logic                           vga_clk,
   input  logic                           sys_rst_n,
   input  logic [flappy_pkg::coord_w-1:0] pix_x,
   input  logic [flappy_pkg::coord_w-1:0] pix_y,
   input  logic [flappy_pkg::coord_w-1:0] bird_x,
   input  logic [flappy_pkg::coord_w-1:0] bird_y,
   input  logic [flappy_pkg::coord_w-1:0] pipe1_x,
   input  logic [flappy_pkg::coord_w-1:0] pipe2_x,
   input  logic [flappy_pkg::len_w-1:0]   pipe1_len,
   input  logic [flappy_pkg::len_w-1:0]   pipe2_len,
   output logic                           bird_on,
   output logic                           pipe_body_on,
   output logic                           pipe_head_on,
   output logic                           over_on,
   output logic                           ground_on
);
   import flappy_pkg::*;

   logic       bird_hit;
   logic [1:0] pipe1_hit;   // {body, head}
   logic [1:0] pipe2_hit;
   logic       over_hit;
   logic       ground_hit;

   // body above and below the opening with a head cap on each side of the gap
   function automatic logic [1:0] pipe_decode(
      input logic [coord_w-1:0] px,
      input logic [coord_w-1:0] py,
      input logic [coord_w-1:0] x,
      input logic [len_w-1:0]   len
   );
      int  col;
      int  row;
      int  top_end;   // first row below the upper body
      int  gap_end;   // first row of the lower body
      logic in_col;
      logic body;
      logic head;
      col     = int'(px);
      row     = int'(py);
      top_end = seg_h * int'(len);
      gap_end = seg_h * (int'(len) + gap_segs);
      in_col  = (col >= int'(x)) && (col < int'(x) + pipe_w);
      body    = (row < top_end) || ((row >= gap_end) && (row < v_valid));
      head    = ((row >= top_end) && (row < top_end + head_h)) ||
                ((row >= gap_end - head_h) && (row < gap_end));
      return {in_col && body, in_col && head};
   endfunction

   always_comb begin
      bird_hit = (int'(pix_x) >= int'(bird_x)) && (int'(pix_x) < int'(bird_x) + bird_w) &&
                 (int'(pix_y) >= int'(bird_y)) && (int'(pix_y) < int'(bird_y) + bird_h);
      pipe1_hit = pipe_decode(pix_x, pix_y, pipe1_x, pipe1_len);
      pipe2_hit = pipe_decode(pix_x, pix_y, pipe2_x, pipe2_len);
      over_hit  = (pix_x >= coord_w'(over_x0)) && (pix_x <= coord_w'(over_x1)) &&
                  (pix_y >= coord_w'(over_y0)) && (pix_y <= coord_w'(over_y1));
      ground_hit = (pix_y >= coord_w'(ground_top)) && (pix_y < coord_w'(v_valid));
   end

   // flags line up with the next cycle
   always_ff @(posedge vga_clk or negedge sys_rst_n) begin
      if (!sys_rst_n) begin
         bird_on      <= 1'b0;
         pipe_body_on <= 1'b0;
         pipe_head_on <= 1'b0;
         over_on      <= 1'b0;
         ground_on    <= 1'b0;
      end else begin
         bird_on      <= bird_hit;
         pipe_body_on <= pipe1_hit[1] || pipe2_hit[1];
         pipe_head_on <= pipe1_hit[0] || pipe2_hit[0];
         over_on      <= over_hit;
         ground_on    <= ground_hit;
      end
   end

endmodule

// ==== hdl/pixel_mux.sv ====
`timescale 1ns/10ps

module pixel_mux (
   input  logic        bird_on,
   input  logic        pipe_body_on,
   input  logic        pipe_head_on,
   input  logic        over_on,
   input  logic        ground_on,
   input  logic        wing_up,
   input  logic        game_over,
   output logic [15:0] pix_data
);
   import flappy_pkg::*;

   logic [15:0] bird_col;

   // solid box colour follows the wing phase
   assign bird_col = wing_up ? col_bird_up : col_bird_down;

   // highest layer first
   always_comb begin
      if (game_over && over_on)
         pix_data = col_over;        // banner only after the crash
      else if (pipe_head_on)
         pix_data = col_pipe_head;
      else if (pipe_body_on)
         pix_data = col_pipe_body;
      else if (bird_on)
         pix_data = bird_col;
      else if (ground_on)
         pix_data = col_ground;
      else
         pix_data = col_sky;         // nothing else covers it
   end

endmodule

// ==== hdl/flappy_top.sv ====
`timescale 1ns/10ps

module flappy_top (
   input  logic                           vga_clk,
   input  logic                           sys_rst_n,
   input  logic [flappy_pkg::coord_w-1:0] pix_x,
   input  logic [flappy_pkg::coord_w-1:0] pix_y,
   input  logic                           flap_n,
   input  logic                           left_n,
   input  logic                           right_n,
   input  logic                           run,
   output logic [15:0]                    pix_data,
   output logic [flappy_pkg::score_w-1:0] score,
   output logic                           game_over
);
   import flappy_pkg::*;

   // game state to decode stage
   logic [coord_w-1:0] bird_x;
   logic [coord_w-1:0] bird_y;
   logic [coord_w-1:0] pipe1_x;
   logic [coord_w-1:0] pipe2_x;
   logic [len_w-1:0]   pipe1_len;
   logic [len_w-1:0]   pipe2_len;
   logic               wing_up;

   // registered layer flags
   logic bird_on;
   logic pipe_body_on;
   logic pipe_head_on;
   logic over_on;
   logic ground_on;

   flight_ctrl u_flight_ctrl (
      .vga_clk      (vga_clk),
      .sys_rst_n    (sys_rst_n),
      .pix_x        (pix_x),
      .pix_y        (pix_y),
      .flap_n       (flap_n),
      .left_n       (left_n),
      .right_n      (right_n),
      .run          (run),
      .bird_on      (bird_on),
      .pipe_body_on (pipe_body_on),
      .pipe_head_on (pipe_head_on),
      .bird_x       (bird_x),
      .bird_y       (bird_y),
      .pipe1_x      (pipe1_x),
      .pipe2_x      (pipe2_x),
      .pipe1_len    (pipe1_len),
      .pipe2_len    (pipe2_len),
      .wing_up      (wing_up),
      .game_over    (game_over),
      .score        (score)
   );

   layer_hit u_layer_hit (
      .vga_clk      (vga_clk),
      .sys_rst_n    (sys_rst_n),
      .pix_x        (pix_x),
      .pix_y        (pix_y),
      .bird_x       (bird_x),
      .bird_y       (bird_y),
      .pipe1_x      (pipe1_x),
      .pipe2_x      (pipe2_x),
      .pipe1_len    (pipe1_len),
      .pipe2_len    (pipe2_len),
      .bird_on      (bird_on),
      .pipe_body_on (pipe_body_on),
      .pipe_head_on (pipe_head_on),
      .over_on      (over_on),
      .ground_on    (ground_on)
   );

   pixel_mux u_pixel_mux (
      .bird_on      (bird_on),
      .pipe_body_on (pipe_body_on),
      .pipe_head_on (pipe_head_on),
      .over_on      (over_on),
      .ground_on    (ground_on),
      .wing_up      (wing_up),
      .game_over    (game_over),
      .pix_data     (pix_data)
   );

endmodule

// ==== sim/tb_flappy.sv ====
`timescale 1ns/10ps

module tb_flappy;
   import flappy_pkg::*;

   localparam int num_tests  = 16;
   localparam int rst_cycles = 16;

   logic               vga_clk;
   logic               sys_rst_n;
   logic [coord_w-1:0] pix_x;
   logic [coord_w-1:0] pix_y;
   logic               flap_n;
   logic               left_n;
   logic               right_n;
   logic               run;
   logic [15:0]        pix_data;
   logic [score_w-1:0] score;
   logic               game_over;

   // test table
   string              test_name   [num_tests];
   logic               flap_t      [num_tests];
   logic               left_t      [num_tests];
   logic               right_t     [num_tests];
   logic               run_t       [num_tests];
   int                 ticks_t     [num_tests];  // frame ticks before the probe
   logic [coord_w-1:0] probe_x_t   [num_tests];
   logic [coord_w-1:0] probe_y_t   [num_tests];
   logic [15:0]        exp_pix_t   [num_tests];
   int                 exp_score_t [num_tests];
   logic               exp_over_t  [num_tests];
   int                 row_cnt;

   // reference game state stepped once per driven edge
   int m_bird_x;
   int m_bird_y;
   int m_phase;
   int m_pipe1_x;
   int m_pipe2_x;
   int m_score;
   bit m_over;

   int test_errs;
   int pass_cnt;
   int fail_cnt;
   int cycle_cnt;
   int cycle_limit;
   int total_cycles;

   flappy_top dut0 (
      .vga_clk   (vga_clk),
      .sys_rst_n (sys_rst_n),
      .pix_x     (pix_x),
      .pix_y     (pix_y),
      .flap_n    (flap_n),
      .left_n    (left_n),
      .right_n   (right_n),
      .run       (run),
      .pix_data  (pix_data),
      .score     (score),
      .game_over (game_over)
   );

   always #2 vga_clk = ~vga_clk;  // 4 ns period

   task automatic add_row(input string name, input bit k_flap, input bit k_left,
                          input bit k_right, input bit k_run, input int ticks,
                          input int px, input int py, input logic [15:0] pix,
                          input int exp_score, input bit exp_over);
      test_name[row_cnt]   = name;
      flap_t[row_cnt]      = k_flap;
      left_t[row_cnt]      = k_left;
      right_t[row_cnt]     = k_right;
      run_t[row_cnt]       = k_run;
      ticks_t[row_cnt]     = ticks;
      probe_x_t[row_cnt]   = coord_w'(px);
      probe_y_t[row_cnt]   = coord_w'(py);
      exp_pix_t[row_cnt]   = pix;
      exp_score_t[row_cnt] = exp_score;
      exp_over_t[row_cnt]  = exp_over;
      row_cnt++;
   endtask

   task automatic check_value(input string name, input string what,
                              input int expected, input int actual);
      if (expected != actual) begin
         $display("Mismatch %s (%s): expected %0h, actual %0h", name, what, expected, actual);
         test_errs++;
      end
   endtask

   // game rules for one clock edge with or without a tick
   task automatic step_model(input bit tick, input bit k_flap, input bit k_left,
                             input bit k_right, input bit k_run);
      bit oob;
      oob = (m_bird_y > death_y) || (m_bird_x > h_valid);
      if (tick && !m_over) begin
         if (m_bird_x == m_pipe1_x || m_bird_x == m_pipe1_x - 1 ||
             m_bird_x == m_pipe2_x || m_bird_x == m_pipe2_x - 1)
            m_score = (m_score + 1) % (1 << score_w);
         if (k_run) begin
            if (m_phase < 8) begin
               m_bird_y = m_bird_y + fall_step;
               if (!k_flap)
                  m_phase = 8;
               else if (m_phase < 7)
                  m_phase = m_phase + 1;
            end else begin
               m_bird_y = m_bird_y - rise_step[m_phase - 8];
               m_phase  = (m_phase == 15) ? 0 : m_phase + 1;
            end
            if (!k_left)
               m_bird_x = m_bird_x - steer_step;
            else if (!k_right)
               m_bird_x = m_bird_x + steer_step;
            m_pipe1_x = (m_pipe1_x > 2) ? m_pipe1_x - pipe_step : pipe_wrap_x;
            m_pipe2_x = (m_pipe2_x > 2) ? m_pipe2_x - pipe_step : pipe_wrap_x;
         end
      end
      if (oob)
         m_over = 1'b1;  // latches one edge late
   endtask

   task automatic run_row(input int i);
      int k;
      test_errs = 0;
      flap_n    = flap_t[i];
      left_n    = left_t[i];
      right_n   = right_t[i];
      run       = run_t[i];
      for (k = 0; k < ticks_t[i]; k++) begin
         pix_x = '0;  // first pixel of a frame
         pix_y = '0;
         @(posedge vga_clk);
         #1;
         step_model(1'b1, flap_t[i], left_t[i], right_t[i], run_t[i]);
         check_value(test_name[i], "score on tick", m_score, int'(score));
      end
      pix_x = probe_x_t[i];
      pix_y = probe_y_t[i];
      @(posedge vga_clk);
      #1;  // flags for the probe are registered now
      step_model(1'b0, flap_t[i], left_t[i], right_t[i], run_t[i]);
      check_value(test_name[i], "pix_data", int'(exp_pix_t[i]), int'(pix_data));
      check_value(test_name[i], "score", exp_score_t[i], int'(score));
      check_value(test_name[i], "game_over", int'(exp_over_t[i]), int'(game_over));
      if (test_errs == 0) begin
         pass_cnt++;
         $display("test %s: ok", test_name[i]);
      end else begin
         fail_cnt++;
         $display("test %s: failed with %0d errors", test_name[i], test_errs);
      end
   endtask

   // watchdog
   initial begin
      cycle_cnt = 0;
      wait (cycle_limit > 0);
      while (cycle_cnt < cycle_limit) begin
         @(posedge vga_clk);
         cycle_cnt++;
      end
      $display("timeout: the tests did not finish within %0d clock cycles", cycle_limit);
      $display("TESTBENCH FAILED");
      $finish;
   end

   initial begin
      vga_clk     = 1'b0;
      sys_rst_n   = 1'b0;
      pix_x       = coord_w'(639);
      pix_y       = coord_w'(479);
      flap_n      = 1'b1;
      left_n      = 1'b1;
      right_n     = 1'b1;
      run         = 1'b0;
      row_cnt     = 0;
      pass_cnt    = 0;
      fail_cnt    = 0;
      cycle_limit = 0;

      m_bird_x  = bird_x0;
      m_bird_y  = bird_y0;
      m_phase   = 0;
      m_pipe1_x = pipe1_x0;
      m_pipe2_x = pipe2_x0;
      m_score   = 0;
      m_over    = 1'b0;

      //       name           fl lf rt run ticks  x    y   pixel         score over
      add_row("reset_sky",    1, 1, 1, 0,  0,    0,  100, col_sky,       0, 0);
      add_row("reset_ground", 1, 1, 1, 0,  0,    0,  400, col_ground,    0, 0);
      add_row("fall_4",       1, 1, 1, 1,  4,  310,  240, col_bird_down, 1, 0);  // y 231
      add_row("fall_8",       1, 1, 1, 1,  8,  310,  256, col_bird_up,   1, 0);  // y 247
      add_row("flap",         0, 1, 1, 1,  1,  303,  249, col_bird_up,   1, 0);
      add_row("rise",         1, 1, 1, 1,  8,  310,  180, col_bird_down, 1, 0);  // up 69 rows
      add_row("rise_edge",    1, 1, 1, 1,  0,  310,  179, col_sky,       1, 0);
      add_row("steer_left",   1, 0, 1, 1,  2,  293,  190, col_bird_down, 1, 0);
      add_row("steer_edge",   1, 1, 1, 1,  0,  292,  190, col_sky,       1, 0);
      add_row("pipe_body",    1, 1, 1, 1,  5,  525,   94, col_pipe_body, 1, 0);  // pipe1 at 520
      add_row("pipe_head",    1, 1, 1, 1,  0,  525,  104, col_pipe_head, 1, 0);
      add_row("paused",       1, 1, 1, 0,  6,  519,   94, col_sky,       1, 0);
      add_row("steer_right",  1, 1, 0, 1, 30,  443,  254, col_bird_down, 1, 0);
      add_row("pass_pipe",    1, 1, 1, 1, 10,  100,  400, col_ground,    2, 0);
      add_row("fall_out",     1, 1, 1, 1, 80,  300,  240, col_over,      2, 1);
      add_row("frozen",       1, 1, 1, 1, 10,  289,   50, col_sky,       2, 1);  // pipe1 stays at 290

      total_cycles = rst_cycles;
      for (int i = 0; i < num_tests; i++)
         total_cycles = total_cycles + ticks_t[i] + 1;
      cycle_limit = 2 * total_cycles;

      repeat (rst_cycles) @(posedge vga_clk);
      #1;
      sys_rst_n = 1'b1;

      for (int i = 0; i < num_tests; i++)
         run_row(i);

      $display("%0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
      if (fail_cnt == 0)
         $display("TESTBENCH PASSED");
      else
         $display("TESTBENCH FAILED");
      $finish;
   end

endmodule

// ==== src.f ====
hdl/flappy_pkg.sv
hdl/flight_ctrl.sv
hdl/layer_hit.sv
hdl/pixel_mux.sv
hdl/flappy_top.sv
sim/tb_flappy.sv

// ==== Makefile ====
TOP := tb_flappy

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --timescale 1ns/10ps -f src.f --top-module $(TOP) -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir
